//--- all.f
source/rp_analog_pkg.sv
source/rp_reset_sync.sv
source/rp_adc_frontend.sv
source/rp_dac_backend.sv
source/rp_analog_top.sv
testbench/tb_clock_gen.sv
testbench/tb_rp_analog.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the analog data path testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=tb_rp_analog
OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" \
  -Mdir "$OBJ_DIR" -f all.f > "$BUILD_LOG" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build exited with status $build_status"
  exit 1
fi

"./$OBJ_DIR/V$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Regression passed" "$SIM_LOG"; then
  echo "Pass line found in $SIM_LOG"
  exit 0
else
  echo "Pass line missing from $SIM_LOG"
  exit 1
fi

//--- source/rp_adc_frontend.sv
/*
  ADC capture stage, one register per channel.
  Reserved low bits of the raw word are dropped.
  Loopback output is combinational from dac_sum_i.
*/

`timescale 1ns/1ps
`default_nettype none

module rp_adc_frontend import rp_analog_pkg::*; #(
  parameter int unsigned CH_NUM = 2  // Channel count, 1 or more
) (
  input  logic                  adc_clk,         // Converter clock
  input  logic                  rst_n_i,         // Sync reset, active low
  input  adc_raw_t [CH_NUM-1:0] adc_raw_i,       // Raw ADC pins
  input  sample_t  [CH_NUM-1:0] dac_sum_i,       // DAC-bound samples
  input  logic                  digital_loop_i,  // Loopback select, level
  output sample_t  [CH_NUM-1:0] adc_dat_o        // Two's complement samples
);

  //////////////////////////////////////////////////
  // Code conversion
  //////////////////////////////////////////////////

  sample_t [CH_NUM-1:0] adc_conv;  // Converted, not yet registered
  sample_t [CH_NUM-1:0] adc_q;     // IO capture registers

  // Negative slope to two's complement
  // Keep the sign bit, invert the magnitude bits
  for (genvar ch = 0; ch < CH_NUM; ch++)
  begin : g_conv
    assign adc_conv[ch] = {adc_raw_i[ch].adc_code[SAMPLE_W-1],
                           ~adc_raw_i[ch].adc_code[SAMPLE_W-2:0]};
  end : g_conv

  //////////////////////////////////////////////////
  // Capture registers
  //////////////////////////////////////////////////

  // One edge from pin to output
  // Reset value is sample zero so a quiet output reads 0
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_q <= '0;
    end
    else
    begin
      for (int ch = 0; ch < CH_NUM; ch++)
      begin
        adc_q[ch] <= adc_conv[ch];  // Reserved bits never reach here
      end
    end
  end

  //////////////////////////////////////////////////
  // Loopback select
  //////////////////////////////////////////////////

  // Loopback bypasses the capture register entirely,
  // so the DAC sum appears in the same cycle
  always_comb
  begin
    for (int ch = 0; ch < CH_NUM; ch++)
    begin
      if (digital_loop_i)
      begin
        adc_dat_o[ch] = dac_sum_i[ch];  // DAC-bound sample
      end
      else
      begin
        adc_dat_o[ch] = adc_q[ch];      // Converter sample
      end
    end
  end

endmodule : rp_adc_frontend

`default_nettype wire

//--- source/rp_analog_pkg.sv
/*
  Sample formats shared by the analog data path.
  Converter codes are 14-bit negative-slope offset codes.
  The ADC word keeps two low bits reserved for a 16-bit part.
*/

`default_nettype none

package rp_analog_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // One converter sample
  localparam int unsigned SAMPLE_W = 14;

  // Sum of two samples, one bit of headroom
  localparam int unsigned SUM_W = SAMPLE_W + 1;

  //////////////////////////////////////////////////
  // Sample types
  //////////////////////////////////////////////////

  // Two's complement sample as seen by the processing blocks
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Offset code as driven to the DAC pins
  // Top bit equals the sample sign, lower bits inverted
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  // Raw word from the ADC pins, MSB first
  typedef struct packed {
    logic [SAMPLE_W-1:0] adc_code;  // Negative-slope offset code
    logic [1:0]          reserved;  // Extra LSBs of a 16-bit converter
  } adc_raw_t;

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  // Offset code of sample zero
  // Sign bit low and all 13 magnitude bits inverted
  localparam dac_code_t DAC_MIDSCALE = {1'b0, {(SAMPLE_W-1){1'b1}}};

  // Code mapping summary
  //   sample  8191 -> code 14'h0000
  //   sample     0 -> code 14'h1FFF
  //   sample    -1 -> code 14'h2000
  //   sample -8192 -> code 14'h3FFF
  // Conversion is its own inverse, so ADC and DAC use the same rule

endpackage : rp_analog_pkg

`default_nettype wire

//--- source/rp_analog_top.sv
/*
  Two-channel analog data path, single adc_clk domain.
  Lock status and all processing samples are ports.
  Both DAC channels leave as one registered array.
*/

`timescale 1ns/1ps
`default_nettype none

module rp_analog_top import rp_analog_pkg::*; #(
  parameter int unsigned CH_NUM = 2  // Channel count, 1 or more
) (
  // Clock and reset
  input  logic                   adc_clk,         // Converter clock
  input  logic                   arst_n_i,        // Board reset, async, active low
  input  logic                   pll_locked_i,    // PLL lock status
  // Configuration
  input  logic                   digital_loop_i,  // ADC outputs show DAC sums
  // ADC side
  input  adc_raw_t  [CH_NUM-1:0] adc_raw_i,       // Raw converter words
  output sample_t   [CH_NUM-1:0] adc_dat_o,       // Acquired samples
  // DAC side
  input  sample_t   [CH_NUM-1:0] gen_dat_i,       // Generator samples
  input  sample_t   [CH_NUM-1:0] ctl_dat_i,       // Controller samples
  output dac_code_t [CH_NUM-1:0] dac_dat_o,       // DAC pin codes
  output logic                   dac_rst_o        // DAC reset, active high
);

  //////////////////////////////////////////////////
  // Local signals
  //////////////////////////////////////////////////

  logic                 rst_n;    // Synchronized reset, active low
  sample_t [CH_NUM-1:0] dac_sum;  // Saturated sums for loopback

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////

  rp_reset_sync i_reset_sync (
    .adc_clk      (adc_clk     ),
    .arst_n_i     (arst_n_i    ),
    .pll_locked_i (pll_locked_i),  // Lock loss restarts reset
    .rst_n_o      (rst_n       )
  );

  //////////////////////////////////////////////////
  // ADC capture
  //////////////////////////////////////////////////

  rp_adc_frontend #(
    .CH_NUM (CH_NUM)
  ) i_adc_frontend (
    .adc_clk        (adc_clk       ),
    .rst_n_i        (rst_n         ),
    .adc_raw_i      (adc_raw_i     ),
    .dac_sum_i      (dac_sum       ),  // Loopback source
    .digital_loop_i (digital_loop_i),
    .adc_dat_o      (adc_dat_o     )
  );

  //////////////////////////////////////////////////
  // DAC output
  //////////////////////////////////////////////////

  // Sum is also the loopback path, so saturation
  // is decided here only
  rp_dac_backend #(
    .CH_NUM (CH_NUM)
  ) i_dac_backend (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n    ),
    .gen_dat_i (gen_dat_i),
    .ctl_dat_i (ctl_dat_i),
    .dac_sum_o (dac_sum  ),  // Combinational
    .dac_dat_o (dac_dat_o),  // One cycle after inputs
    .dac_rst_o (dac_rst_o)   // One edge after rst_n
  );

endmodule : rp_analog_top

`default_nettype wire

//--- source/rp_dac_backend.sv
/*
  DAC output stage, one cycle from inputs to pins.
  gen + ctl is summed in SUM_W bits and saturated to 14 bits.
  dac_sum_o is combinational and feeds the ADC loopback.
*/

`timescale 1ns/1ps
`default_nettype none

module rp_dac_backend import rp_analog_pkg::*; #(
  parameter int unsigned CH_NUM = 2  // Channel count, 1 or more
) (
  input  logic                   adc_clk,    // Converter clock
  input  logic                   rst_n_i,    // Sync reset, active low
  input  sample_t   [CH_NUM-1:0] gen_dat_i,  // Generator samples
  input  sample_t   [CH_NUM-1:0] ctl_dat_i,  // Controller samples
  output sample_t   [CH_NUM-1:0] dac_sum_o,  // Saturated sums
  output dac_code_t [CH_NUM-1:0] dac_dat_o,  // DAC pin codes, registered
  output logic                   dac_rst_o   // DAC reset, active high
);

  //////////////////////////////////////////////////
  // Sum and saturation
  //////////////////////////////////////////////////

  dac_code_t [CH_NUM-1:0] dac_code;  // Offset code before the register

  for (genvar ch = 0; ch < CH_NUM; ch++)
  begin : g_sum
    logic signed [SUM_W-1:0] sum;   // Sign-extended sum
    logic                    ovf;   // Sum left the 14-bit range

    assign sum = gen_dat_i[ch] + ctl_dat_i[ch];

    // Top two bits differ only on overflow
    assign ovf = sum[SUM_W-1] ^ sum[SUM_W-2];

    // Clamp toward the sign: 0x1FFF for positive, 0x2000 for negative
    assign dac_sum_o[ch] = ovf ? {sum[SUM_W-1], {(SAMPLE_W-1){~sum[SUM_W-1]}}}
                               : sum[SAMPLE_W-1:0];

    // Two's complement to negative-slope offset code
    assign dac_code[ch] = {dac_sum_o[ch][SAMPLE_W-1],
                           ~dac_sum_o[ch][SAMPLE_W-2:0]};
  end : g_sum

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  // Pins park at midscale while in reset
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_o <= {CH_NUM{DAC_MIDSCALE}};
    end
    else
    begin
      for (int ch = 0; ch < CH_NUM; ch++)
      begin
        dac_dat_o[ch] <= dac_code[ch];  // New sample every cycle
      end
    end
  end

  // DAC reset is the registered inverse of rst_n_i
  // Set at once, released one edge after rst_n_i rises
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_rst_o <= 1'b1;
    end
    else
    begin
      dac_rst_o <= 1'b0;  // rst_n_i is high on this path
    end
  end

endmodule : rp_dac_backend

`default_nettype wire

//--- source/rp_reset_sync.sv
/*
  Reset release for the adc_clk domain.
  Assert is asynchronous, release is two adc_clk edges after
  arst_n_i and pll_locked_i are both high. Lock loss restarts it.
*/

`timescale 1ns/1ps
`default_nettype none

module rp_reset_sync (
  input  logic adc_clk,       // Converter clock
  input  logic arst_n_i,      // Board reset, async, active low
  input  logic pll_locked_i,  // PLL lock status, level
  output logic rst_n_o        // Synchronized reset, active low
);

  //////////////////////////////////////////////////
  // Two-stage synchronizer
  //////////////////////////////////////////////////

  logic [1:0] sync_q;  // [0] first stage, [1] output stage

  // Lock is the shifted-in value, so a lost lock
  // pulls the output low on the second edge after it drops
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sync_q <= 2'b00;                       // Immediate assert
    end
    else
    begin
      sync_q <= {sync_q[0], pll_locked_i};   // Shift lock status in
    end
  end

  // Single release point for the whole data path
  assign rst_n_o = sync_q[1];

endmodule : rp_reset_sync

`default_nettype wire

//--- testbench/tb_clock_gen.sv
/*
  Free-running adc_clk and board reset for the testbench.
  Reset is released 1 ns after the last reset edge.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS  = 8,  // Clock period
  parameter int unsigned RST_CYCLES = 4   // Edges with reset held low
) (
  output logic adc_clk,   // Converter clock
  output logic arst_n_o   // Board reset, active low
);

  initial
  begin
    adc_clk = 1'b0;
    forever #(PERIOD_NS / 2) adc_clk = ~adc_clk;
  end

  // Release away from the edge, like every other input
  initial
  begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    #1 arst_n_o = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

//--- testbench/tb_rp_analog.sv
/*
  Self-checking testbench for rp_analog_top with two channels.
  Inputs change 1 ns after the rising edge. Outputs are read 1 ns
  later, before the edge, and again 1 ns after the following edge.
  Stops at the first mismatch.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_rp_analog import rp_analog_pkg::*; ();

  localparam int unsigned CH_NUM = 2;
  localparam int MAX_SAMPLE = 2 ** (SAMPLE_W - 1) - 1;  // 8191
  localparam int MIN_SAMPLE = -(2 ** (SAMPLE_W - 1));   // -8192
  localparam logic [SAMPLE_W-1:0] MAG_MASK = {1'b0, {(SAMPLE_W-1){1'b1}}};

  // One table row, stimulus and expected outputs
  typedef struct packed {
    adc_raw_t  [CH_NUM-1:0] raw;
    sample_t   [CH_NUM-1:0] gen;
    sample_t   [CH_NUM-1:0] ctl;
    logic                   loop;
    sample_t   [CH_NUM-1:0] exp_adc;
    dac_code_t [CH_NUM-1:0] exp_dac;
  } entry_t;

  logic                   adc_clk;
  logic                   arst_n;
  logic                   pll_locked;
  logic                   digital_loop;
  adc_raw_t  [CH_NUM-1:0] adc_raw;
  sample_t   [CH_NUM-1:0] gen_dat;
  sample_t   [CH_NUM-1:0] ctl_dat;
  sample_t   [CH_NUM-1:0] adc_dat;
  dac_code_t [CH_NUM-1:0] dac_dat;
  logic                   dac_rst;

  entry_t entries_q[$];  // Stimulus table
  int     seed;          // $random state

  tb_clock_gen #(
    .PERIOD_NS  (8),
    .RST_CYCLES (4)
  ) i_clock_gen (
    .adc_clk  (adc_clk),
    .arst_n_o (arst_n )
  );

  rp_analog_top #(
    .CH_NUM (CH_NUM)
  ) i_dut (
    .adc_clk        (adc_clk     ),
    .arst_n_i       (arst_n      ),
    .pll_locked_i   (pll_locked  ),
    .digital_loop_i (digital_loop),
    .adc_raw_i      (adc_raw     ),
    .adc_dat_o      (adc_dat     ),
    .gen_dat_i      (gen_dat     ),
    .ctl_dat_i      (ctl_dat     ),
    .dac_dat_o      (dac_dat     ),
    .dac_rst_o      (dac_rst     )
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Negative slope code: sign kept, 13 magnitude bits inverted
  function automatic sample_t code_to_sample(input logic [SAMPLE_W-1:0] code);
    return sample_t'(code ^ MAG_MASK);
  endfunction

  function automatic dac_code_t sample_to_code(input sample_t s);
    return dac_code_t'(s) ^ MAG_MASK;
  endfunction

  // Full-precision sum, then clamp to the 14-bit range
  function automatic sample_t sat_sum(input sample_t a, input sample_t b);
    int total;
    total = int'(a) + int'(b);
    if (total > MAX_SAMPLE)
    begin
      total = MAX_SAMPLE;
    end
    else if (total < MIN_SAMPLE)
    begin
      total = MIN_SAMPLE;
    end
    return sample_t'(total);
  endfunction

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input int actual, input int expected);
    if (actual != expected)
    begin
      abort_run($sformatf("FAILED at time %0t: %s got %0d, expected %0d",
                          $time, what, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////

  task automatic add_entry(input logic [15:0] raw0, input logic [15:0] raw1,
                           input int gen0, input int ctl0,
                           input int gen1, input int ctl1, input logic loop);
    entry_t  e;
    sample_t sum;
    e.raw[0] = raw0;
    e.raw[1] = raw1;
    e.gen[0] = sample_t'(gen0);
    e.ctl[0] = sample_t'(ctl0);
    e.gen[1] = sample_t'(gen1);
    e.ctl[1] = sample_t'(ctl1);
    e.loop   = loop;
    for (int ch = 0; ch < CH_NUM; ch++)
    begin
      sum = sat_sum(e.gen[ch], e.ctl[ch]);
      e.exp_dac[ch] = sample_to_code(sum);
      e.exp_adc[ch] = loop ? sum : code_to_sample(e.raw[ch].adc_code);  // Loop ignores ADC
    end
    entries_q.push_back(e);
  endtask

  task automatic build_table();
    logic [15:0] r0;
    logic [15:0] r1;
    int          g0;
    int          c0;
    int          g1;
    int          c1;
    logic        lp;
    // ADC codes at the four corners, reserved bits varied
    add_entry({14'h0000, 2'b11}, {14'h1FFF, 2'b01}, 0, 0, 0, 0, 1'b0);
    add_entry({14'h2000, 2'b10}, {14'h3FFF, 2'b00}, 0, 0, 0, 0, 1'b0);
    add_entry({14'h0000, 2'b00}, {14'h1FFF, 2'b10}, 0, 0, 0, 0, 1'b0);
    add_entry({14'h3FFF, 2'b11}, {14'h2000, 2'b01}, 0, 0, 0, 0, 1'b0);
    // In-range sums
    add_entry(16'h1234, 16'hBEEF, 1000, 234, -4000, -123, 1'b0);
    add_entry(16'h8001, 16'h7FFE, 8191, 0, -8192, 0, 1'b0);
    add_entry(16'h4443, 16'hCCCC, -1, 0, 4096, 4095, 1'b0);
    // Saturation both ways
    add_entry(16'h0000, 16'h0000, 8191, 1, -8192, -1, 1'b0);
    add_entry(16'hFFFF, 16'hFFFF, 8191, 8191, -8192, -8192, 1'b0);
    // Loopback, ADC pins should not matter
    add_entry(16'hFFFF, 16'h0000, 12, -7, -300, 299, 1'b1);
    add_entry(16'h5A5A, 16'hA5A5, 5000, 5000, -6000, -6000, 1'b1);
    add_entry(16'h0000, 16'hFFFF, 0, 0, 8191, 1, 1'b1);
    // Random rows, sums kept inside the range
    for (int i = 0; i < 16; i++)
    begin
      r0 = 16'($random(seed));
      r1 = 16'($random(seed));
      g0 = $random(seed) % 4096;
      c0 = $random(seed) % 4096;
      g1 = $random(seed) % 4096;
      c1 = $random(seed) % 4096;
      lp = (($random(seed) % 3) == 0);
      add_entry(r0, r1, g0, c0, g1, c1, lp);
    end
  endtask

  //////////////////////////////////////////////////
  // Waits and checks
  //////////////////////////////////////////////////

  // Polled on the falling edge, away from the release time
  task automatic wait_arst_release(input int max_cycles);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < max_cycles && !seen; n++)
    begin
      @(negedge adc_clk);
      seen = arst_n;
    end
    if (!seen)
    begin
      abort_run($sformatf("Timeout: board reset still low after %0d cycles", max_cycles));
    end
  endtask

  task automatic wait_dac_rst(input logic level, input int max_cycles, input string what);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < max_cycles && !seen; n++)
    begin
      @(posedge adc_clk);
      #1;
      seen = (dac_rst == level);
    end
    if (!seen)
    begin
      abort_run($sformatf("Timeout: no %s within %0d cycles", what, max_cycles));
    end
  endtask

  task automatic check_reset_state(input string when);
    check_value({when, " dac_rst_o"}, int'(dac_rst), 1);
    for (int ch = 0; ch < CH_NUM; ch++)
    begin
      check_value($sformatf("%s dac_dat_o[%0d]", when, ch), int'(dac_dat[ch]),
                  int'(DAC_MIDSCALE));
      check_value($sformatf("%s adc_dat_o[%0d]", when, ch), int'(adc_dat[ch]), 0);
    end
  endtask

  // Entered and left 1 ns after a rising edge
  // Before the edge the registers still show the previous samples
  task automatic run_table(input string pass_name);
    entry_t                 e;
    int                     n_entries;
    adc_raw_t  [CH_NUM-1:0] prev_raw;  // Words captured at the last edge
    dac_code_t [CH_NUM-1:0] prev_dac;  // Codes registered at the last edge
    sample_t                mid_adc;   // adc_dat_o expected before the edge
    n_entries = entries_q.size();
    prev_raw  = adc_raw;
    for (int ch = 0; ch < CH_NUM; ch++)
    begin
      prev_dac[ch] = sample_to_code(sat_sum(gen_dat[ch], ctl_dat[ch]));
    end
    for (int i = 0; i < n_entries; i++)
    begin
      e            = entries_q[i];
      adc_raw      = e.raw;
      gen_dat      = e.gen;
      ctl_dat      = e.ctl;
      digital_loop = e.loop;
      #1;
      // Loopback is combinational, the capture path is not
      for (int ch = 0; ch < CH_NUM; ch++)
      begin
        mid_adc = e.loop ? e.exp_adc[ch] : code_to_sample(prev_raw[ch].adc_code);
        check_value($sformatf("%s entry %0d adc_dat_o[%0d] before edge", pass_name, i, ch),
                    int'(adc_dat[ch]), int'(mid_adc));
        check_value($sformatf("%s entry %0d dac_dat_o[%0d] before edge", pass_name, i, ch),
                    int'(dac_dat[ch]), int'(prev_dac[ch]));
      end
      @(posedge adc_clk);
      #1;
      for (int ch = 0; ch < CH_NUM; ch++)
      begin
        check_value($sformatf("%s entry %0d adc_dat_o[%0d]", pass_name, i, ch),
                    int'(adc_dat[ch]), int'(e.exp_adc[ch]));
        check_value($sformatf("%s entry %0d dac_dat_o[%0d]", pass_name, i, ch),
                    int'(dac_dat[ch]), int'(e.exp_dac[ch]));
      end
      check_value($sformatf("%s entry %0d dac_rst_o", pass_name, i), int'(dac_rst), 0);
      prev_raw = e.raw;
      prev_dac = e.exp_dac;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    pll_locked   = 1'b1;
    digital_loop = 1'b0;
    adc_raw      = '0;
    gen_dat      = '0;
    ctl_dat      = '0;
    seed         = 88;
    build_table();

    // Board reset still held here
    repeat (2) @(posedge adc_clk);
    #1;
    check_reset_state("during board reset");
    wait_arst_release(20);
    wait_dac_rst(1'b0, 8, "DAC reset release after board reset");

    run_table("first pass");

    // Lock loss must pull the whole path back into reset
    digital_loop = 1'b0;
    pll_locked   = 1'b0;
    wait_dac_rst(1'b1, 8, "DAC reset after PLL lock loss");
    check_reset_state("after lock loss");
    pll_locked = 1'b1;
    wait_dac_rst(1'b0, 8, "DAC reset release after relock");

    run_table("after relock");

    $display("Regression passed");
    $finish;
  end

endmodule : tb_rp_analog

`default_nettype wire
